// ==== build.f ====
design/mips_pkg.sv
design/decode_if.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/exec_core.sv
verification/exec_core_sva.sv
verification/tb_clock_gen.sv
verification/tb_exec_core.sv

// ==== design/alu.sv ====
`timescale 1ns/100ps

module alu
    import mips_pkg::*;
(
    input  alu_op_e           i_op,
    input  logic [DATA_W-1:0] i_a,
    input  logic [DATA_W-1:0] i_b,
    input  logic [4:0]        i_shamt,
    output logic [DATA_W-1:0] o_result
);

    logic a_lt_b;

    // Signed compare for SLT and SLTI
    assign a_lt_b = $signed(i_a) < $signed(i_b);

    always_comb
    begin
        case (i_op)
            // Wrapping arithmetic, no overflow trap
            ALU_ADD:
            begin
                o_result = i_a + i_b;
            end
            ALU_SUB:
            begin
                o_result = i_a - i_b;
            end
            ALU_AND:
            begin
                o_result = i_a & i_b;
            end
            ALU_OR:
            begin
                o_result = i_a | i_b;
            end
            ALU_XOR:
            begin
                o_result = i_a ^ i_b;
            end
            ALU_NOR:
            begin
                o_result = ~(i_a | i_b);
            end
            ALU_SLT:
            begin
                o_result = {{(DATA_W-1){1'b0}}, a_lt_b};
            end
            // Shifts act on rt, not rs
            ALU_SLL:
            begin
                o_result = i_b << i_shamt;
            end
            ALU_SRL:
            begin
                o_result = i_b >> i_shamt;
            end
            ALU_LUI:
            begin
                o_result = {i_b[15:0], 16'h0000};
            end
            default:
            begin
                o_result = '0;
            end
        endcase
    end

endmodule

// ==== design/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if
    import mips_pkg::*;
();

    // Register fields
    logic [REG_AW-1:0] rs_addr;
    logic [REG_AW-1:0] rt_addr;
    logic [REG_AW-1:0] dest_addr;

    // Operation and operand B source
    alu_op_e           alu_op;
    logic              use_imm;
    logic [DATA_W-1:0] imm;     // already extended
    logic [4:0]        shamt;

    // Valid-qualified strobes, never both high
    logic              reg_write;
    logic              illegal;

    modport dec (
        output rs_addr, rt_addr, dest_addr, alu_op, use_imm, imm, shamt, reg_write, illegal
    );

    modport dp (
        input rs_addr, rt_addr, dest_addr, alu_op, use_imm, imm, shamt, reg_write, illegal
    );

endinterface

// ==== design/exec_core.sv ====
`timescale 1ns/100ps

module exec_core
    import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_valid,
    input  logic [DATA_W-1:0] i_instr,
    output logic              o_valid,
    output logic [DATA_W-1:0] o_result,
    output logic              o_illegal
);

    logic [DATA_W-1:0] rs_data;
    logic [DATA_W-1:0] rt_data;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_result;

    decode_if dec_bus ();

    //////////////////////////////
    // Decode and operand fetch
    //////////////////////////////

    instr_decoder u_decoder (
        .i_instr (i_instr),
        .i_valid (i_valid),
        .dec     (dec_bus.dec)
    );

    // Write data comes straight from the ALU, same edge as the outputs
    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (dec_bus.reg_write),
        .i_rs_addr (dec_bus.rs_addr),
        .i_rt_addr (dec_bus.rt_addr),
        .i_wr_addr (dec_bus.dest_addr),
        .i_wr_data (alu_result),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////

    assign alu_b = dec_bus.use_imm ? dec_bus.imm : rt_data;

    alu u_alu (
        .i_op     (dec_bus.alu_op),
        .i_a      (rs_data),
        .i_b      (alu_b),
        .i_shamt  (dec_bus.shamt),
        .o_result (alu_result)
    );

    // One-cycle output stage
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
            o_result  <= '0;
        end
        else
        begin
            o_valid   <= i_valid;
            o_illegal <= dec_bus.illegal;
            if (i_valid)
            begin
                o_result <= alu_result;
            end
        end
    end

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder
    import mips_pkg::*;
(
    input  logic [DATA_W-1:0] i_instr,
    input  logic              i_valid,
    decode_if.dec             dec
);

    opcode_e     opcode;
    funct_e      funct;
    logic [15:0] imm16;
    logic        known;

    //////////////////////////////
    // Field split
    //////////////////////////////

    assign opcode      = opcode_e'(i_instr[31:26]);
    assign funct       = funct_e'(i_instr[5:0]);
    assign imm16       = i_instr[15:0];
    assign dec.rs_addr = i_instr[25:21];
    assign dec.rt_addr = i_instr[20:16];
    assign dec.shamt   = i_instr[10:6];

    //////////////////////////////
    // Control decode
    //////////////////////////////

    always_comb
    begin
        dec.alu_op    = ALU_ADD;
        dec.use_imm   = 1'b0;
        dec.imm       = '0;
        dec.dest_addr = i_instr[20:16];   // rt for I-type
        known         = 1'b1;

        case (opcode)
            OP_RTYPE:
            begin
                dec.dest_addr = i_instr[15:11];
                case (funct)
                    F_SLL:   dec.alu_op = ALU_SLL;
                    F_SRL:   dec.alu_op = ALU_SRL;
                    F_ADDU:  dec.alu_op = ALU_ADD;
                    F_SUBU:  dec.alu_op = ALU_SUB;
                    F_AND:   dec.alu_op = ALU_AND;
                    F_OR:    dec.alu_op = ALU_OR;
                    F_XOR:   dec.alu_op = ALU_XOR;
                    F_NOR:   dec.alu_op = ALU_NOR;
                    F_SLT:   dec.alu_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            // Sign-extended immediates
            OP_ADDIU, OP_SLTI:
            begin
                dec.alu_op  = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
                dec.use_imm = 1'b1;
                dec.imm     = {{(DATA_W-16){imm16[15]}}, imm16};
            end
            // Zero-extended immediates
            OP_ANDI, OP_ORI, OP_LUI:
            begin
                case (opcode)
                    OP_ANDI: dec.alu_op = ALU_AND;
                    OP_ORI:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_LUI;
                endcase
                dec.use_imm = 1'b1;
                dec.imm     = {{(DATA_W-16){1'b0}}, imm16};
            end
            default:
            begin
                known = 1'b0;
            end
        endcase
    end

    // Unknown codes never write back
    assign dec.reg_write = i_valid & known;
    assign dec.illegal   = i_valid & ~known;

endmodule

// ==== design/mips_pkg.sv ====
package mips_pkg;

    //////////////////////////////
    // Widths fixed by the encoding
    //////////////////////////////

    localparam int DATA_W = 32;
    localparam int REG_AW = 5;
    localparam int N_REGS = 32;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f
    } opcode_e;

    // R-type function code, instr[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a
    } funct_e;

    // Operation selected for the ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file
    import mips_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_we,
    input  logic [REG_AW-1:0] i_rs_addr,
    input  logic [REG_AW-1:0] i_rt_addr,
    input  logic [REG_AW-1:0] i_wr_addr,
    input  logic [DATA_W-1:0] i_wr_data,
    output logic [DATA_W-1:0] o_rs_data,
    output logic [DATA_W-1:0] o_rt_data
);

    logic [DATA_W-1:0] regs [N_REGS];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < N_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_wr_addr != '0))
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // r0 is hardwired to zero
    assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the exec_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_exec_core \
    -f build.f \
    -o sim_exec_core

./obj_dir/sim_exec_core

// ==== verification/exec_core_sva.sv ====
`timescale 1ns/100ps

module exec_core_sva (
    input logic i_clk,
    input logic i_rst,
    input logic i_valid,
    input logic i_out_valid,
    input logic i_out_illegal,
    input logic i_reg_write,
    input logic i_dec_illegal
);

    // Output stage comes out of reset idle
    a_idle_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_out_valid)
        else $error("o_valid high in the cycle after reset");

    // Fixed one-cycle latency, in both directions
    a_valid_follows: assert property (
        @(posedge i_clk) disable iff (i_rst) i_valid |=> i_out_valid)
        else $error("o_valid missing one cycle after i_valid");

    a_no_extra_valid: assert property (
        @(posedge i_clk) disable iff (i_rst) !i_valid |=> !i_out_valid)
        else $error("o_valid high without i_valid in the cycle before");

    a_illegal_has_valid: assert property (
        @(posedge i_clk) disable iff (i_rst) i_out_illegal |-> i_out_valid)
        else $error("o_illegal high while o_valid is low");

    // Illegal instructions never reach the write port
    a_no_illegal_write: assert property (
        @(posedge i_clk) disable iff (i_rst) !(i_dec_illegal && i_reg_write))
        else $error("register write enabled for an illegal instruction");

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    // 4 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // Reset seen by two rising edges, dropped on a falling edge
    initial
    begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// ==== verification/tb_exec_core.sv ====
`timescale 1ns/100ps

module tb_exec_core
    import mips_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 50;

    typedef struct packed {
        logic              illegal;
        alu_op_e           op;
        logic [REG_AW-1:0] dest;
        logic [DATA_W-1:0] result;
    } expect_t;

    logic              clk;
    logic              rst;
    logic              stim_valid;
    logic [DATA_W-1:0] stim_instr;
    logic              out_valid;
    logic [DATA_W-1:0] out_result;
    logic              out_illegal;

    logic [DATA_W-1:0] model_regs [N_REGS];
    expect_t           expected_q [$];

    funct_e  rtype_ops [7] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT};
    opcode_e imm_ops [5]   = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI};

    tb_clock_gen clk_gen0 (
        .o_clk (clk),
        .o_rst (rst)
    );

    exec_core dut0 (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_valid   (stim_valid),
        .i_instr   (stim_instr),
        .o_valid   (out_valid),
        .o_result  (out_result),
        .o_illegal (out_illegal)
    );

    bind exec_core exec_core_sva sva0 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_valid       (i_valid),
        .i_out_valid   (o_valid),
        .i_out_illegal (o_illegal),
        .i_reg_write   (dec_bus.reg_write),
        .i_dec_illegal (dec_bus.illegal)
    );

    //////////////////////////////
    // Encoding and reference model
    //////////////////////////////

    function automatic logic [DATA_W-1:0] rtype_word(input funct_e f, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [4:0] rd,
                                                     input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, f};
    endfunction

    function automatic logic [DATA_W-1:0] itype_word(input opcode_e op, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [REG_AW-1:0] rand_reg();
        return REG_AW'($urandom());
    endfunction

    function automatic expect_t outcome(input alu_op_e op, input logic [DATA_W-1:0] value);
        expect_t e;
        e.illegal = 1'b0;
        e.op      = op;
        e.dest    = '0;
        e.result  = value;
        return e;
    endfunction

    // Expected result from the instruction word and the model registers
    function automatic expect_t predict(input logic [DATA_W-1:0] instr);
        expect_t           e;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] simm;
        logic [DATA_W-1:0] zimm;
        logic [4:0]        sh;
        a    = model_regs[instr[25:21]];
        b    = model_regs[instr[20:16]];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        sh   = instr[10:6];
        e    = outcome(ALU_ADD, '0);
        e.illegal = 1'b1;
        case (instr[31:26])
            OP_RTYPE:
            begin
                case (instr[5:0])
                    F_ADDU:  e = outcome(ALU_ADD, a + b);
                    F_SUBU:  e = outcome(ALU_SUB, a - b);
                    F_AND:   e = outcome(ALU_AND, a & b);
                    F_OR:    e = outcome(ALU_OR, a | b);
                    F_XOR:   e = outcome(ALU_XOR, a ^ b);
                    F_NOR:   e = outcome(ALU_NOR, ~(a | b));
                    F_SLT:   e = outcome(ALU_SLT, {31'd0, $signed(a) < $signed(b)});
                    F_SLL:   e = outcome(ALU_SLL, b << sh);
                    F_SRL:   e = outcome(ALU_SRL, b >> sh);
                    default: e.illegal = 1'b1;
                endcase
                e.dest = instr[15:11];
            end
            OP_ADDIU: e = outcome(ALU_ADD, a + simm);
            OP_SLTI:  e = outcome(ALU_SLT, {31'd0, $signed(a) < $signed(simm)});
            OP_ANDI:  e = outcome(ALU_AND, a & zimm);
            OP_ORI:   e = outcome(ALU_OR, a | zimm);
            OP_LUI:   e = outcome(ALU_LUI, {instr[15:0], 16'h0000});
            default:  e.illegal = 1'b1;
        endcase
        if (instr[31:26] != OP_RTYPE)
            e.dest = instr[20:16];
        return e;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input logic [DATA_W-1:0] actual,
                                input logic [DATA_W-1:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: o_result = %h, expected %h", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_illegal(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: o_illegal = %b, expected %b", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_alu_op(input alu_op_e actual, input alu_op_e expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: decoder alu_op = %s, expected %s",
                     $time, actual.name(), expected.name());
            abort_run();
        end
    endtask

    // Every output beat is matched against the oldest expectation
    // Outputs are unknown until the first reset edge
    always @(negedge clk)
    begin
        expect_t front;
        if ((rst === 1'b0) && out_valid)
        begin
            if (expected_q.size() == 0)
            begin
                $display("o_valid went high at %0t with no instruction outstanding", $time);
                abort_run();
            end
            else
            begin
                front = expected_q.pop_front();
                check_illegal(out_illegal, front.illegal);
                if (!front.illegal)
                    check_result(out_result, front.result);
            end
        end
        else if (rst === 1'b0)
        begin
            check_illegal(out_illegal, 1'b0);
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic issue(input logic [DATA_W-1:0] instr);
        expect_t e;
        @(negedge clk);
        stim_valid = 1'b1;
        stim_instr = instr;
        e = predict(instr);
        expected_q.push_back(e);
        if (!e.illegal && (e.dest != '0))
            model_regs[e.dest] = e.result;
        // Decoder output settles well before the next rising edge
        #1;
        if (!e.illegal)
            check_alu_op(dut0.dec_bus.alu_op, e.op);
    endtask

    // Junk on the instruction bus while valid is low
    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            stim_valid = 1'b0;
            stim_instr = $urandom();
        end
    endtask

    initial
    begin
        int         cycles;
        logic [4:0] sh;
        void'($urandom(32'hb310d976));
        stim_valid = 1'b0;
        stim_instr = '0;
        for (int i = 0; i < N_REGS; i++)
            model_regs[i] = '0;

        // Hold off until reset has been released
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("Timeout: reset was never released");
                abort_run();
            end
        end
        while (rst !== 1'b0);

        // Quiet outputs, then reads of the cleared register file
        idle(4);
        foreach (rtype_ops[k])
            if (rtype_ops[k] != F_NOR)
                issue(rtype_word(rtype_ops[k], rand_reg(), rand_reg(), rand_reg(), 5'd0));
        issue(rtype_word(F_SLL, 5'd0, rand_reg(), rand_reg(), 5'd7));
        issue(rtype_word(F_SRL, 5'd0, rand_reg(), rand_reg(), 5'd3));

        // Full 32-bit contents in every register
        for (int r = 1; r < N_REGS; r++)
        begin
            issue(itype_word(OP_LUI, 5'd0, 5'(r), 16'($urandom())));
            issue(itype_word(OP_ORI, 5'(r), 5'(r), 16'($urandom())));
        end
        // Signed compare around the sign boundary
        issue(itype_word(OP_LUI, 5'd0, 5'd1, 16'h7fff));
        issue(itype_word(OP_ORI, 5'd1, 5'd1, 16'hffff));
        issue(itype_word(OP_LUI, 5'd0, 5'd2, 16'h8000));
        issue(rtype_word(F_SLT, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(rtype_word(F_SLT, 5'd2, 5'd1, 5'd4, 5'd0));
        repeat (40)
            issue(rtype_word(rtype_ops[$urandom_range(6)], rand_reg(), rand_reg(),
                             rand_reg(), 5'd0));
        idle(2);

        // Immediate forms, negative immediates included
        issue(itype_word(OP_ADDIU, 5'd0, 5'd10, 16'hffff));
        issue(itype_word(OP_SLTI, 5'd10, 5'd11, 16'h0000));
        issue(itype_word(OP_ANDI, 5'd10, 5'd12, 16'h8001));
        repeat (30)
            issue(itype_word(imm_ops[$urandom_range(4)], rand_reg(), rand_reg(), 16'($urandom())));

        // Shift amounts 0 and 31 first, then random ones
        for (int k = 0; k < 10; k++)
        begin
            sh = (k == 0) ? 5'd0 : (k == 1) ? 5'd31 : 5'($urandom());
            issue(rtype_word(F_SLL, 5'd0, rand_reg(), rand_reg(), sh));
            issue(rtype_word(F_SRL, 5'd0, rand_reg(), rand_reg(), sh));
        end

        // Back-to-back dependency chain
        for (int k = 0; k < 8; k++)
        begin
            issue(itype_word(OP_ADDIU, 5'd5, 5'd5, 16'($urandom())));
            issue(rtype_word(F_ADDU, 5'd5, 5'd6, 5'd6, 5'd0));
        end
        // r0 ignores writes
        issue(itype_word(OP_ADDIU, 5'd4, 5'd0, 16'h1234));
        issue(rtype_word(F_OR, 5'd0, 5'd0, 5'd7, 5'd0));
        issue(rtype_word(F_NOR, 5'd0, 5'd0, 5'd0, 5'd0));
        issue(rtype_word(F_ADDU, 5'd0, 5'd4, 5'd7, 5'd0));

        // Illegal opcodes and function code aimed at r8, then r8 read back
        issue({6'h3f, 5'd1, 5'd8, 16'h1234});
        issue({6'h08, 5'd1, 5'd8, 16'h0001});
        issue({6'h00, 5'd1, 5'd2, 5'd8, 5'd0, 6'h3f});
        issue(rtype_word(F_OR, 5'd8, 5'd0, 5'd9, 5'd0));

        cycles = 0;
        idle(1);
        while ((expected_q.size() != 0) && (cycles < TIMEOUT_CYCLES))
        begin
            idle(1);
            cycles++;
        end
        idle(3);
        if (expected_q.size() == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("Timeout: %0d results never appeared on o_valid", expected_q.size());
            abort_run();
        end
    end

endmodule
